// ==== hdl/spi_ctrl_defines.svh ====
/* host bus addresses, spi register offsets, control word,
   dac command codes, power threshold and core count */
`ifndef SPI_CTRL_DEFINES_SVH
`define SPI_CTRL_DEFINES_SVH

// six current sources plus the opp board
`define SPI_NUM_CORES       7

// decoded host write addresses
`define ADDR_CCS_DACSET     8'h10
`define ADDR_CCS_DACOFFSET  8'h11
`define ADDR_CCS_ADCRV      8'h12
`define ADDR_CCS_ADCMV      8'h13

// spi core register map
`define OFFSET_SPI_CTRL     2'b00
`define OFFSET_SPI_DATA     2'b01

// rx irq on, 16 bit frames, clk/8, sample on falling edge
`define SPI_CFG_WORD        16'h585d

`define DAC_CHA             2'b00
`define DAC_CHB             2'b01
`define DAC_WRITE_UPDATE    2'b01

// set values above this count as powered
`define DAC_JUDSET_MIN      12'h0c8

`endif

// ==== hdl/spi_bus_pkg.sv ====
/* spi core side types: data word, register offset, core mask,
   request and response structs */
`include "spi_ctrl_defines.svh"

package spi_bus_pkg;

	typedef logic [15:0] spi_word_t;
	typedef logic [1:0] spi_offset_t;

	// one bit per core, all ones for a broadcast
	typedef logic [`SPI_NUM_CORES-1:0] spi_mask_t;

	// sequencer to cores, shared offset and data
	typedef struct packed
	{
		spi_mask_t   we;
		spi_mask_t   stb;     // single cycle pulse
		spi_offset_t offset;
		spi_word_t   data;
	} spi_req_t;

	// cores to sequencer
	typedef struct packed
	{
		spi_mask_t ack;
		spi_mask_t irq;
	} spi_rsp_t;

endpackage

// ==== hdl/dac_job_pkg.sv ====
/* job side types: dac code, target select, pending host requests,
   done pulses and sequencer states */
package dac_job_pkg;

	typedef logic [11:0] dac_code_t;

	// 0 all cores, 1..6 single core, 7 none
	typedef logic [2:0] dac_target_t;

	typedef struct packed
	{
		logic        dacset_pend;
		logic        offset_pend;
		logic        adc_pend;
		dac_code_t   dacset_code;
		dac_target_t dacset_tgt;
		dac_code_t   offset_code;
		dac_target_t offset_tgt;
	} host_req_t;

	// one cycle each, clears the matching pending bit
	typedef struct packed
	{
		logic dacset;
		logic offset;
		logic adc;
		logic analog;
	} job_done_t;

	typedef enum logic [2:0]
	{
		IDLE,
		ADC_CONFIG,
		ADC_RD,
		DAC_CONFIG,
		DACSET_WR,
		DACOFFSET_WR
	} seq_state_t;

endpackage

// ==== hdl/fsmc_req_capture.sv ====
`timescale 1ns/1ps
/* host bus capture: strobe synchronizers, write edge decode
   and the pending dac set, dac offset and adc requests */
`include "spi_ctrl_defines.svh"

module fsmc_req_capture
(
	input  logic                   clk64_i,
	input  logic                   rstn_i,
	input  logic                   fsmc_csn_i,
	input  logic                   fsmc_wrn_i,
	input  logic [7:0]             fsmc_addr_i,
	input  spi_bus_pkg::spi_word_t fsmc_data_i,
	input  logic                   ang_busy_i,   // analog job waiting
	input  dac_job_pkg::job_done_t done_i,
	output dac_job_pkg::host_req_t host_req_o,
	output logic                   adc_chnl_o    // 0 rv, 1 mv
);
	import spi_bus_pkg::*;
	import dac_job_pkg::*;

	logic csn_s1, csn_s2;
	logic wrn_s1, wrn_s2, wrn_s3;
	logic [7:0] addr_q;
	spi_word_t data_q;
	logic wr_edge;
	logic dacset_pend, offset_pend, adc_pend;
	dac_code_t dacset_code, offset_code;
	dac_target_t dacset_tgt, offset_tgt;

	always_ff @(posedge clk64_i or negedge rstn_i)
		if (!rstn_i)
		begin
			csn_s1 <= 1'b1;
			csn_s2 <= 1'b1;
			wrn_s1 <= 1'b1;
			wrn_s2 <= 1'b1;
			wrn_s3 <= 1'b1;
		end
		else
		begin
			csn_s1 <= fsmc_csn_i;
			csn_s2 <= csn_s1;
			wrn_s1 <= fsmc_wrn_i;
			wrn_s2 <= wrn_s1;
			wrn_s3 <= wrn_s2;
		end

	// bus is stable while the strobe is low
	always_ff @(posedge clk64_i)
		if (!wrn_s1)
		begin
			addr_q <= fsmc_addr_i;
			data_q <= fsmc_data_i;
		end

	assign wr_edge = wrn_s2 & ~wrn_s3 & ~csn_s2;   // end of write

	always_ff @(posedge clk64_i or negedge rstn_i)
		if (!rstn_i)
		begin
			dacset_pend <= 1'b0;
			offset_pend <= 1'b0;
			adc_pend <= 1'b0;
			adc_chnl_o <= 1'b0;
		end
		else if (ang_busy_i)
		begin
			dacset_pend <= 1'b0;   // host locked out
			offset_pend <= 1'b0;
			adc_pend <= 1'b0;
		end
		else
		begin
			if (done_i.dacset)
				dacset_pend <= 1'b0;
			if (done_i.offset)
				offset_pend <= 1'b0;
			if (done_i.adc)
				adc_pend <= 1'b0;
			// a new write wins over a done pulse
			if (wr_edge)
			begin
				case (addr_q)
					`ADDR_CCS_DACSET: dacset_pend <= 1'b1;
					`ADDR_CCS_DACOFFSET: offset_pend <= 1'b1;
					`ADDR_CCS_ADCRV:
					begin
						adc_pend <= 1'b1;
						adc_chnl_o <= 1'b0;
					end
					`ADDR_CCS_ADCMV:
					begin
						adc_pend <= 1'b1;
						adc_chnl_o <= 1'b1;
					end
					default: ;
				endcase
			end
		end

	// a repeat write only refreshes code and target
	always_ff @(posedge clk64_i)
		if (wr_edge && !ang_busy_i)
		begin
			if (addr_q == `ADDR_CCS_DACSET)
			begin
				dacset_code <= data_q[11:0];
				dacset_tgt <= data_q[14:12];
			end
			if (addr_q == `ADDR_CCS_DACOFFSET)
			begin
				offset_code <= data_q[11:0];
				offset_tgt <= data_q[14:12];
			end
		end

	assign host_req_o.dacset_pend = dacset_pend;
	assign host_req_o.offset_pend = offset_pend;
	assign host_req_o.adc_pend = adc_pend;
	assign host_req_o.dacset_code = dacset_code;
	assign host_req_o.dacset_tgt = dacset_tgt;
	assign host_req_o.offset_code = offset_code;
	assign host_req_o.offset_tgt = offset_tgt;

endmodule

// ==== hdl/ang_da_capture.sv ====
`timescale 1ns/1ps
/* analog update capture: synchronizer, rising edge detect,
   pending analog set value request with its code */
module ang_da_capture
(
	input  logic                   clk64_i,
	input  logic                   rstn_i,
	input  logic                   da_set_mod_i,     // analog dac mode
	input  logic                   ang_da_update_i,
	input  dac_job_pkg::dac_code_t ang_da_data_i,
	input  dac_job_pkg::job_done_t done_i,
	output logic                   ang_pend_o,
	output dac_job_pkg::dac_code_t ang_code_o
);
	import dac_job_pkg::*;

	logic upd_s1, upd_s2, upd_s3;
	logic upd_rise;

	// idle high so a line held high after reset gives no edge
	always_ff @(posedge clk64_i or negedge rstn_i)
		if (!rstn_i)
		begin
			upd_s1 <= 1'b1;
			upd_s2 <= 1'b1;
			upd_s3 <= 1'b1;
		end
		else
		begin
			upd_s1 <= ang_da_update_i;
			upd_s2 <= upd_s1;
			upd_s3 <= upd_s2;
		end

	assign upd_rise = upd_s2 & ~upd_s3;

	always_ff @(posedge clk64_i or negedge rstn_i)
		if (!rstn_i)
			ang_pend_o <= 1'b0;
		else if (!da_set_mod_i)
			ang_pend_o <= 1'b0;   // mode off cancels
		else if (upd_rise)
			ang_pend_o <= 1'b1;
		else if (done_i.analog)
			ang_pend_o <= 1'b0;

	always_ff @(posedge clk64_i)
		if (da_set_mod_i && upd_rise)
			ang_code_o <= ang_da_data_i;

endmodule

// ==== hdl/spi_job_sequencer.sv ====
`timescale 1ns/1ps
/* job sequencer: control then data write on the spi cores,
   core masks, data words, done pulses and set power flags */
`include "spi_ctrl_defines.svh"

module spi_job_sequencer
(
	input  logic                   clk64_i,
	input  logic                   rstn_i,
	input  logic                   da_set_mod_i,
	input  dac_job_pkg::host_req_t host_req_i,
	input  logic                   ang_pend_i,
	input  dac_job_pkg::dac_code_t ang_code_i,
	input  spi_bus_pkg::spi_rsp_t  spi_rsp_i,
	output spi_bus_pkg::spi_req_t  spi_req_o,
	output dac_job_pkg::job_done_t done_o,
	output logic                   ccs_adda_sel_o,   // 1 while a dac job runs
	output logic                   dac_setpower_o
);
	import spi_bus_pkg::*;
	import dac_job_pkg::*;

	seq_state_t state, state_nxt, state_d1;
	logic ack_any, irq_q;
	logic entry;
	logic job_ang;     // set value job came from the analog side
	logic no_core_q;   // data write went to no core
	logic ang_power, host_power;
	dac_code_t set_code;
	spi_mask_t sel_mask, we_q, stb_q;
	spi_offset_t offset_q;
	spi_word_t data_q;

	function automatic spi_mask_t tgt_mask(input dac_target_t tgt);
		spi_mask_t m;
		if (tgt == 3'd0)
			m = '1;
		else if (tgt == 3'd7)
			m = '0;
		else
			m = spi_mask_t'(1) << (tgt - 3'd1);
		return m;
	endfunction

	assign ack_any = |spi_rsp_i.ack;
	assign set_code = job_ang ? ang_code_i : host_req_i.dacset_code;
	assign entry = (state != state_d1) && (state != IDLE);

	always_ff @(posedge clk64_i or negedge rstn_i)
		if (!rstn_i)
		begin
			state <= IDLE;
			state_d1 <= IDLE;
			irq_q <= 1'b0;
			job_ang <= 1'b0;
			no_core_q <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			state_d1 <= state;
			irq_q <= |spi_rsp_i.irq;
			if (state == DAC_CONFIG && ack_any)
				job_ang <= ang_pend_i;
			if (entry)
				no_core_q <= (sel_mask == '0);
		end

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (!irq_q)   // last interrupt must be gone
				begin
					if (ang_pend_i || host_req_i.dacset_pend || host_req_i.offset_pend)
						state_nxt = DAC_CONFIG;
					else if (host_req_i.adc_pend)
						state_nxt = ADC_CONFIG;
				end
			ADC_CONFIG:
				if (ack_any)
					state_nxt = ADC_RD;
			DAC_CONFIG:
				if (ack_any)
				begin
					if (ang_pend_i || host_req_i.dacset_pend)
						state_nxt = DACSET_WR;
					else if (host_req_i.offset_pend)
						state_nxt = DACOFFSET_WR;
					else
						state_nxt = IDLE;   // request withdrawn
				end
			ADC_RD:
				if (irq_q)
					state_nxt = IDLE;
			DACSET_WR, DACOFFSET_WR:
				if (irq_q || no_core_q)
					state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_comb
		case (state)
			DACSET_WR: sel_mask = job_ang ? '1 : tgt_mask(host_req_i.dacset_tgt);
			DACOFFSET_WR: sel_mask = tgt_mask(host_req_i.offset_tgt);
			default: sel_mask = '1;   // config and adc go to all cores
		endcase

	always_ff @(posedge clk64_i or negedge rstn_i)
		if (!rstn_i)
		begin
			we_q <= '0;
			stb_q <= '0;
		end
		else
		begin
			we_q <= entry ? sel_mask : '0;
			stb_q <= entry ? sel_mask : '0;
		end

	always_ff @(posedge clk64_i)
		if (entry)
			case (state)
				ADC_RD:
				begin
					offset_q <= `OFFSET_SPI_DATA;
					data_q <= '0;   // dummy frame clocks the adc out
				end
				DACSET_WR:
				begin
					offset_q <= `OFFSET_SPI_DATA;
					data_q <= {`DAC_CHA, `DAC_WRITE_UPDATE, set_code};
				end
				DACOFFSET_WR:
				begin
					offset_q <= `OFFSET_SPI_DATA;
					data_q <= {`DAC_CHB, `DAC_WRITE_UPDATE, host_req_i.offset_code};
				end
				default:
				begin
					offset_q <= `OFFSET_SPI_CTRL;
					data_q <= `SPI_CFG_WORD;
				end
			endcase

	always_ff @(posedge clk64_i or negedge rstn_i)
		if (!rstn_i)
		begin
			ang_power <= 1'b0;
			host_power <= 1'b0;
		end
		else if (entry && state == DACSET_WR)
		begin
			if (job_ang)
				ang_power <= (set_code > `DAC_JUDSET_MIN);
			else
				host_power <= (set_code > `DAC_JUDSET_MIN);
		end

	assign done_o.dacset = (state == DACSET_WR) && (state_nxt == IDLE) && !job_ang;
	assign done_o.analog = (state == DACSET_WR) && (state_nxt == IDLE) && job_ang;
	assign done_o.offset = (state == DACOFFSET_WR) && (state_nxt == IDLE);
	assign done_o.adc = (state == ADC_RD) && (state_nxt == IDLE);

	assign spi_req_o.we = we_q;
	assign spi_req_o.stb = stb_q;
	assign spi_req_o.offset = offset_q;
	assign spi_req_o.data = data_q;

	assign ccs_adda_sel_o = (state == DAC_CONFIG) || (state == DACSET_WR) ||
		(state == DACOFFSET_WR);
	assign dac_setpower_o = da_set_mod_i ? ang_power : host_power;

endmodule

// ==== hdl/spi_ctrl_top.sv ====
`timescale 1ns/1ps
/* spi control unit top: host capture, analog capture and job sequencer */
module spi_ctrl_top
(
	input  logic                    clk64_i,
	input  logic                    rstn_i,
	input  logic                    da_set_mod_i,
	input  logic                    fsmc_csn_i,
	input  logic                    fsmc_wrn_i,
	input  logic [7:0]              fsmc_addr_i,
	input  spi_bus_pkg::spi_word_t  fsmc_data_i,
	input  logic                    ang_da_update_i,
	input  dac_job_pkg::dac_code_t  ang_da_data_i,
	output spi_bus_pkg::spi_mask_t  spi_we_o,
	output spi_bus_pkg::spi_mask_t  spi_stb_o,
	output spi_bus_pkg::spi_offset_t spi_addr_o,
	output spi_bus_pkg::spi_word_t  spi_data_o,
	input  spi_bus_pkg::spi_mask_t  spi_ack_i,
	input  spi_bus_pkg::spi_mask_t  spi_irq_i,
	output logic                    adc_chnl_o,
	output logic                    ccs_adda_sel_o,
	output logic                    dac_setpower_o
);
	import spi_bus_pkg::*;
	import dac_job_pkg::*;

	host_req_t host_req;
	job_done_t done;
	logic ang_pend;
	dac_code_t ang_code;
	spi_req_t spi_req;
	spi_rsp_t spi_rsp;

	fsmc_req_capture u_fsmc
	(
		.clk64_i     (clk64_i),
		.rstn_i      (rstn_i),
		.fsmc_csn_i  (fsmc_csn_i),
		.fsmc_wrn_i  (fsmc_wrn_i),
		.fsmc_addr_i (fsmc_addr_i),
		.fsmc_data_i (fsmc_data_i),
		.ang_busy_i  (ang_pend),
		.done_i      (done),
		.host_req_o  (host_req),
		.adc_chnl_o  (adc_chnl_o)
	);

	ang_da_capture u_ang
	(
		.clk64_i         (clk64_i),
		.rstn_i          (rstn_i),
		.da_set_mod_i    (da_set_mod_i),
		.ang_da_update_i (ang_da_update_i),
		.ang_da_data_i   (ang_da_data_i),
		.done_i          (done),
		.ang_pend_o      (ang_pend),
		.ang_code_o      (ang_code)
	);

	spi_job_sequencer u_seq
	(
		.clk64_i        (clk64_i),
		.rstn_i         (rstn_i),
		.da_set_mod_i   (da_set_mod_i),
		.host_req_i     (host_req),
		.ang_pend_i     (ang_pend),
		.ang_code_i     (ang_code),
		.spi_rsp_i      (spi_rsp),
		.spi_req_o      (spi_req),
		.done_o         (done),
		.ccs_adda_sel_o (ccs_adda_sel_o),
		.dac_setpower_o (dac_setpower_o)
	);

	assign spi_rsp.ack = spi_ack_i;
	assign spi_rsp.irq = spi_irq_i;

	assign spi_we_o = spi_req.we;
	assign spi_stb_o = spi_req.stb;
	assign spi_addr_o = spi_req.offset;
	assign spi_data_o = spi_req.data;

endmodule

// ==== sim/spi_core_model.sv ====
`timescale 1ns/1ps
/* behavioral model of the seven spi cores: acknowledge two cycles
   after a strobe, delayed interrupt pulse after a data write */
`include "spi_ctrl_defines.svh"

module spi_core_model
(
	input  logic                     clk64_i,
	input  logic                     rstn_i,
	input  spi_bus_pkg::spi_mask_t   spi_we_i,
	input  spi_bus_pkg::spi_mask_t   spi_stb_i,
	input  spi_bus_pkg::spi_offset_t spi_addr_i,
	output spi_bus_pkg::spi_mask_t   spi_ack_o,
	output spi_bus_pkg::spi_mask_t   spi_irq_o
);
	import spi_bus_pkg::*;

	localparam int IRQ_LEN = 4;
	localparam int IRQ_MIN_DELAY = 6;
	localparam int IRQ_LAG = 2;   // counter load and output register

	integer seed = 32'hc3eb_88a0;
	spi_mask_t wr_d1;
	spi_mask_t irq_mask;   // cores that took the data frame
	int irq_cnt;           // counts down to the end of the pulse

	always @(posedge clk64_i or negedge rstn_i)
		if (!rstn_i)
		begin
			wr_d1 <= '0;
			spi_ack_o <= '0;
			irq_mask <= '0;
			irq_cnt <= 0;
			spi_irq_o <= '0;
		end
		else
		begin
			wr_d1 <= spi_stb_i & spi_we_i;
			spi_ack_o <= wr_d1;
			if ((spi_stb_i & spi_we_i) != '0 && spi_addr_i == `OFFSET_SPI_DATA)
			begin
				irq_mask <= spi_stb_i & spi_we_i;
				// frame time varies between 6 and 13 cycles
				irq_cnt <= IRQ_MIN_DELAY - IRQ_LAG + IRQ_LEN + ($unsigned($random(seed)) % 8);
			end
			else if (irq_cnt != 0)
				irq_cnt <= irq_cnt - 1;
			spi_irq_o <= (irq_cnt != 0 && irq_cnt <= IRQ_LEN) ? irq_mask : '0;
		end

endmodule

// ==== sim/tb_spi_ctrl.sv ====
`timescale 1ns/1ps
/* testbench for the spi control unit: stimulus table and loop,
   spi core model, transfer monitor, compare tasks and watchdog */
`include "spi_ctrl_defines.svh"

module tb_spi_ctrl;
	import spi_bus_pkg::*;
	import dac_job_pkg::*;

	localparam int K_DAC = 0;       // host dac set value or offset write
	localparam int K_ADC = 1;
	localparam int K_ANALOG = 2;
	localparam int K_LOCKOUT = 3;   // host write while analog job pending
	localparam int K_MODE = 4;      // da_set_mod from data bit 0
	localparam int MAX_ENTRIES = 32;
	localparam int CYCLES_PER_ENTRY = 200;
	localparam int QUIET_CYCLES = 20;

	logic clk64, rstn, da_set_mod;
	logic fsmc_csn, fsmc_wrn;
	logic [7:0] fsmc_addr;
	spi_word_t fsmc_data;
	logic ang_da_update;
	dac_code_t ang_da_data;
	spi_mask_t spi_we, spi_stb, spi_ack, spi_irq;
	spi_offset_t spi_addr;
	spi_word_t spi_data;
	logic adc_chnl, ccs_adda_sel, dac_setpower;

	// stimulus and expected values
	string tab_name[MAX_ENTRIES];
	int tab_kind[MAX_ENTRIES];
	logic [7:0] tab_addr[MAX_ENTRIES];
	spi_word_t tab_data[MAX_ENTRIES];
	spi_mask_t tab_mask[MAX_ENTRIES];
	spi_word_t tab_exp[MAX_ENTRIES];
	logic tab_flag[MAX_ENTRIES];   // power flag, adc channel for adc entries
	int n_entries = 0;

	// one record per strobe
	spi_mask_t mon_we[$];
	spi_mask_t mon_stb[$];
	spi_offset_t mon_offset[$];
	spi_word_t mon_data[$];
	logic mon_sel[$];
	int irq_rises = 0;
	logic irq_prev = 1'b0;

	spi_ctrl_top dut
	(
		.clk64_i         (clk64),
		.rstn_i          (rstn),
		.da_set_mod_i    (da_set_mod),
		.fsmc_csn_i      (fsmc_csn),
		.fsmc_wrn_i      (fsmc_wrn),
		.fsmc_addr_i     (fsmc_addr),
		.fsmc_data_i     (fsmc_data),
		.ang_da_update_i (ang_da_update),
		.ang_da_data_i   (ang_da_data),
		.spi_we_o        (spi_we),
		.spi_stb_o       (spi_stb),
		.spi_addr_o      (spi_addr),
		.spi_data_o      (spi_data),
		.spi_ack_i       (spi_ack),
		.spi_irq_i       (spi_irq),
		.adc_chnl_o      (adc_chnl),
		.ccs_adda_sel_o  (ccs_adda_sel),
		.dac_setpower_o  (dac_setpower)
	);

	spi_core_model cores
	(
		.clk64_i    (clk64),
		.rstn_i     (rstn),
		.spi_we_i   (spi_we),
		.spi_stb_i  (spi_stb),
		.spi_addr_i (spi_addr),
		.spi_ack_o  (spi_ack),
		.spi_irq_o  (spi_irq)
	);

	initial clk64 = 1'b0;
	always #50 clk64 = ~clk64;

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk64)
	begin
		if (spi_stb != '0)
		begin
			mon_we.push_back(spi_we);
			mon_stb.push_back(spi_stb);
			mon_offset.push_back(spi_addr);
			mon_data.push_back(spi_data);
			mon_sel.push_back(ccs_adda_sel);
		end
		if (spi_irq != '0 && !irq_prev)
			irq_rises++;
		irq_prev = (spi_irq != '0);
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_mask(input string name, input spi_mask_t exp, input spi_mask_t act);
		if (act !== exp)
			stop_with_error($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
	endtask

	task automatic check_word(input string name, input spi_word_t exp, input spi_word_t act);
		if (act !== exp)
			stop_with_error($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
	endtask

	task automatic check_offset(input string name, input spi_offset_t exp,
		input spi_offset_t act);
		if (act !== exp)
			stop_with_error($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_with_error($sformatf("Mismatch %s: expected %b actual %b", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			stop_with_error($sformatf("Mismatch %s: expected %0d actual %0d", name, exp, act));
	endtask

	task automatic add_entry(input string name, input int kind, input logic [7:0] addr,
		input spi_word_t data, input spi_mask_t mask, input spi_word_t exp, input logic flag);
		tab_name[n_entries] = name;
		tab_kind[n_entries] = kind;
		tab_addr[n_entries] = addr;
		tab_data[n_entries] = data;
		tab_mask[n_entries] = mask;
		tab_exp[n_entries] = exp;
		tab_flag[n_entries] = flag;
		n_entries++;
	endtask

	// dac words carry channel in 15:14 and write update in 13:12,
	// so channel a reads 16'h1xxx and channel b 16'h5xxx
	task automatic load_table();
		add_entry("dacset t0", K_DAC, `ADDR_CCS_DACSET, 16'h0123, 7'h7f, 16'h1123, 1'b1);
		add_entry("dacset t1", K_DAC, `ADDR_CCS_DACSET, 16'h10c8, 7'h01, 16'h10c8, 1'b0);
		add_entry("dacset t2", K_DAC, `ADDR_CCS_DACSET, 16'h2800, 7'h02, 16'h1800, 1'b1);
		add_entry("dacset t3", K_DAC, `ADDR_CCS_DACSET, 16'h3001, 7'h04, 16'h1001, 1'b0);
		add_entry("dacset t4", K_DAC, `ADDR_CCS_DACSET, 16'h4fff, 7'h08, 16'h1fff, 1'b1);
		add_entry("dacset t5", K_DAC, `ADDR_CCS_DACSET, 16'h50c9, 7'h10, 16'h10c9, 1'b1);
		add_entry("dacset t6", K_DAC, `ADDR_CCS_DACSET, 16'h6050, 7'h20, 16'h1050, 1'b0);
		add_entry("dacset t7", K_DAC, `ADDR_CCS_DACSET, 16'h7010, 7'h00, 16'h1010, 1'b0);
		add_entry("offset t0", K_DAC, `ADDR_CCS_DACOFFSET, 16'h0abc, 7'h7f, 16'h5abc, 1'b0);
		add_entry("offset t3", K_DAC, `ADDR_CCS_DACOFFSET, 16'h3456, 7'h04, 16'h5456, 1'b0);
		add_entry("offset t6", K_DAC, `ADDR_CCS_DACOFFSET, 16'h6001, 7'h20, 16'h5001, 1'b0);
		add_entry("offset t7", K_DAC, `ADDR_CCS_DACOFFSET, 16'h7fff, 7'h00, 16'h5fff, 1'b0);
		add_entry("dacset high", K_DAC, `ADDR_CCS_DACSET, 16'h0400, 7'h7f, 16'h1400, 1'b1);
		add_entry("offset t1", K_DAC, `ADDR_CCS_DACOFFSET, 16'h1200, 7'h01, 16'h5200, 1'b1);
		add_entry("adc rv", K_ADC, `ADDR_CCS_ADCRV, 16'h0000, 7'h7f, 16'h0000, 1'b0);
		add_entry("adc mv", K_ADC, `ADDR_CCS_ADCMV, 16'h0000, 7'h7f, 16'h0000, 1'b1);
		add_entry("adc rv again", K_ADC, `ADDR_CCS_ADCRV, 16'h0000, 7'h7f, 16'h0000, 1'b0);
		add_entry("mode on", K_MODE, 8'h00, 16'h0001, 7'h00, 16'h0000, 1'b0);
		add_entry("analog high", K_ANALOG, 8'h00, 16'h0500, 7'h7f, 16'h1500, 1'b1);
		add_entry("analog low", K_ANALOG, 8'h00, 16'h00a0, 7'h7f, 16'h10a0, 1'b0);
		add_entry("lockout", K_LOCKOUT, `ADDR_CCS_DACSET, 16'h0300, 7'h7f, 16'h1300, 1'b1);
		add_entry("mode off host", K_MODE, 8'h00, 16'h0000, 7'h00, 16'h0000, 1'b1);
		add_entry("mode on analog", K_MODE, 8'h00, 16'h0001, 7'h00, 16'h0000, 1'b1);
		add_entry("dacset in mode", K_DAC, `ADDR_CCS_DACSET, 16'h0010, 7'h7f, 16'h1010, 1'b1);
		add_entry("mode off low", K_MODE, 8'h00, 16'h0000, 7'h00, 16'h0000, 1'b0);
	endtask

	task automatic host_write(input logic [7:0] addr, input spi_word_t data);
		@(negedge clk64);
		fsmc_csn = 1'b0;
		fsmc_addr = addr;
		fsmc_data = data;
		fsmc_wrn = 1'b0;
		repeat (3) @(negedge clk64);
		fsmc_wrn = 1'b1;   // request taken on this edge
		repeat (4) @(negedge clk64);
		fsmc_csn = 1'b1;
	endtask

	task automatic analog_rise(input dac_code_t code);
		@(negedge clk64);
		ang_da_data = code;
		ang_da_update = 1'b1;
	endtask

	// strobes first, then the interrupt pulse, then the dac select drop
	task automatic wait_job(input int base, input int irq_base, input int n_exp,
		input logic with_irq);
		while (mon_stb.size() < base + n_exp)
			@(negedge clk64);
		if (with_irq)
			while (irq_rises == irq_base || spi_irq != '0)
				@(negedge clk64);
		while (ccs_adda_sel)
			@(negedge clk64);
	endtask

	task automatic run_entry(input int i);
		int base;
		int irq_base;
		int n_exp;
		logic exp_sel;
		spi_mask_t em;
		spi_offset_t eo;
		spi_word_t ed;
		base = mon_stb.size();
		irq_base = irq_rises;
		n_exp = (tab_mask[i] == '0) ? 1 : 2;   // no data frame for target none
		exp_sel = (tab_kind[i] != K_ADC);
		if (tab_kind[i] == K_MODE)
		begin
			@(negedge clk64);
			da_set_mod = tab_data[i][0];
			repeat (2) @(negedge clk64);
			check_flag({tab_name[i], " set power"}, tab_flag[i], dac_setpower);
		end
		else
		begin
			case (tab_kind[i])
				K_ANALOG: analog_rise(tab_data[i][11:0]);
				K_LOCKOUT:
				begin
					analog_rise(tab_data[i][11:0]);
					while (mon_stb.size() < base + 1)
						@(negedge clk64);
					host_write(tab_addr[i], tab_data[i]);
				end
				default: host_write(tab_addr[i], tab_data[i]);
			endcase
			wait_job(base, irq_base, n_exp, tab_mask[i] != '0);
			@(negedge clk64);
			ang_da_update = 1'b0;
			if (tab_kind[i] == K_LOCKOUT)
				repeat (QUIET_CYCLES) @(negedge clk64);   // a host job would start here
			check_count({tab_name[i], " transfers"}, n_exp, mon_stb.size() - base);
			for (int k = 0; k < n_exp; k++)
			begin
				if (k == 0)
				begin
					em = '1;
					eo = `OFFSET_SPI_CTRL;
					ed = `SPI_CFG_WORD;
				end
				else
				begin
					em = tab_mask[i];
					eo = `OFFSET_SPI_DATA;
					ed = tab_exp[i];
				end
				check_mask($sformatf("%s frame %0d we", tab_name[i], k), em, mon_we[base + k]);
				check_mask($sformatf("%s frame %0d stb", tab_name[i], k), em, mon_stb[base + k]);
				check_offset($sformatf("%s frame %0d offset", tab_name[i], k), eo,
					mon_offset[base + k]);
				check_word($sformatf("%s frame %0d data", tab_name[i], k), ed, mon_data[base + k]);
				check_flag($sformatf("%s frame %0d adda sel", tab_name[i], k), exp_sel,
					mon_sel[base + k]);
			end
			if (tab_kind[i] == K_ADC)
				check_flag({tab_name[i], " adc channel"}, tab_flag[i], adc_chnl);
			else
				check_flag({tab_name[i], " set power"}, tab_flag[i], dac_setpower);
		end
	endtask

	initial
	begin
		rstn = 1'b0;
		da_set_mod = 1'b0;
		fsmc_csn = 1'b1;
		fsmc_wrn = 1'b1;
		fsmc_addr = 8'h00;
		fsmc_data = '0;
		ang_da_update = 1'b0;
		ang_da_data = '0;
		load_table();
		repeat (10) @(negedge clk64);
		rstn = 1'b1;
		repeat (2) @(negedge clk64);
		for (int i = 0; i < n_entries; i++)
			run_entry(i);
		$display("Finished with no errors");
		$finish;
	end

	initial
	begin
		wait (n_entries > 0);
		repeat (n_entries * CYCLES_PER_ENTRY) @(posedge clk64);
		$display("Timeout: tests did not complete within %0d cycles",
			n_entries * CYCLES_PER_ENTRY);
		$display("Finished with errors");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/spi_bus_pkg.sv
hdl/dac_job_pkg.sv
hdl/fsmc_req_capture.sv
hdl/ang_da_capture.sv
hdl/spi_job_sequencer.sv
hdl/spi_ctrl_top.sv
sim/spi_core_model.sv
sim/tb_spi_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the spi control unit testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_ctrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk -v msg="$(PASS_MSG)" \
		'{ print } index($$0, msg) { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
